// File: rtl/bp_pkg.sv
package bp_pkg;

	////////////////////
	// Widths and sizes
	////////////////////

	localparam int NUM_BANKS = 4;
	localparam int WORD_W    = 16;   // Buffer word
	localparam int LANE_W    = 24;   // PE result lane
	localparam int ROW_W     = 6;
	localparam int ADDR_W    = 8;    // Row plus bank select
	localparam int LEN_W     = 9;    // Line length 1..256
	localparam int SHIFT_W   = 5;

	typedef logic signed [WORD_W-1:0] data_t;
	typedef logic signed [LANE_W-1:0] lane_t;

	// One PE result, pooled or four-lane
	typedef union packed {
		lane_t [NUM_BANKS-1:0] quad;
		struct packed {
			logic [(NUM_BANKS-1)*LANE_W-1:0] pad;
			lane_t value;
		} single;
	} result_u;

	// Buffer write, lane k goes to bank k
	typedef struct packed {
		logic [NUM_BANKS-1:0] mask;
		logic [ROW_W-1:0] row;
		data_t [NUM_BANKS-1:0] lanes;
	} wr_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] st_addr;
		logic pooled;
		logic relu;
		logic [SHIFT_W-1:0] shift;
	} wb_cfg_t;

	typedef struct packed {
		logic [ADDR_W-1:0] st_addr;
		logic [LEN_W-1:0] len;
		logic pad;
	} line_cmd_t;

endpackage

// File: rtl/result_writer.sv
`timescale 1ns/10ps

module result_writer (
	input  logic clk,
	input  logic reset,
	input  logic wb_conf,
	input  bp_pkg::wb_cfg_t wb_cfg,
	input  logic res_valid,
	input  bp_pkg::result_u res,
	output bp_pkg::wr_req_t wb_req
);
	import bp_pkg::*;

	localparam int BANK_W = ADDR_W - ROW_W;
	localparam lane_t SAT_HI = lane_t'((1 <<< (WORD_W - 1)) - 1);
	localparam lane_t SAT_LO = lane_t'(-(1 <<< (WORD_W - 1)));

	logic pooled_q;                 // Mode of the current write-back
	logic relu_q;
	logic [SHIFT_W-1:0] shift_q;
	logic [ADDR_W-1:0] addr_q;      // Next word address
	wr_req_t req_d;
	data_t pool_val;

	// Shift, rectify, clamp to one buffer word
	function automatic data_t scale(input lane_t v, input logic [SHIFT_W-1:0] sh,
			input logic relu);
		lane_t s;
		s = v >>> sh;
		if (relu && s < 0) begin
			s = '0;
		end
		if (s > SAT_HI) begin
			return data_t'(SAT_HI);
		end else if (s < SAT_LO) begin
			return data_t'(SAT_LO);
		end
		return data_t'(s);
	endfunction

	assign pool_val = scale(res.single.value, shift_q, relu_q);

	always_comb begin
		req_d.row  = addr_q[ADDR_W-1:BANK_W];
		req_d.mask = '0;
		if (pooled_q) begin
			req_d.mask[addr_q[BANK_W-1:0]] = 1'b1;   // One-hot bank
			for (int k = 0; k < NUM_BANKS; k++) begin
				req_d.lanes[k] = pool_val;
			end
		end else begin
			req_d.mask = '1;                          // Whole row
			for (int k = 0; k < NUM_BANKS; k++) begin
				req_d.lanes[k] = scale(res.quad[k], shift_q, relu_q);
			end
		end
	end

	////////////////////
	// Mode and address
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pooled_q <= 1'b0;
			relu_q   <= 1'b0;
			shift_q  <= '0;
			addr_q   <= '0;
		end else if (wb_conf) begin
			pooled_q <= wb_cfg.pooled;
			relu_q   <= wb_cfg.relu;
			shift_q  <= wb_cfg.shift;
			addr_q   <= wb_cfg.st_addr;
		end else if (res_valid) begin
			addr_q <= addr_q + (pooled_q ? ADDR_W'(1) : ADDR_W'(NUM_BANKS));
		end
	end

	// Request goes out one cycle after the result
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_req.mask <= '0;
		end else begin
			wb_req.mask <= res_valid ? req_d.mask : '0;
		end
		wb_req.row   <= req_d.row;
		wb_req.lanes <= req_d.lanes;
	end

endmodule

// File: rtl/bank_buffer.sv
`timescale 1ns/10ps

module bank_buffer #(
	parameter int ROWS = 64
) (
	input  logic clk,
	input  logic reset,
	input  logic fill_active,
	input  bp_pkg::wr_req_t fill,
	input  bp_pkg::wr_req_t wb_req,
	input  logic rd_en,
	input  logic [bp_pkg::ROW_W-1:0] rd_row,
	output bp_pkg::data_t rd_data [bp_pkg::NUM_BANKS]
);
	import bp_pkg::*;

	wr_req_t wr_q;                  // Selected source, one cycle behind
	logic [ROW_W-1:0] wr_idx;
	logic [ROW_W-1:0] rd_idx;

	// Rows wrap at the bank depth
	assign wr_idx = ROW_W'(wr_q.row % ROWS);
	assign rd_idx = ROW_W'(rd_row % ROWS);

	////////////////////
	// Source select
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_q.mask <= '0;
		end else begin
			wr_q.mask <= fill_active ? fill.mask : wb_req.mask;   // Fill wins
		end
		wr_q.row   <= fill_active ? fill.row : wb_req.row;
		wr_q.lanes <= fill_active ? fill.lanes : wb_req.lanes;
	end

	////////////////////
	// Banks
	////////////////////

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		data_t mem [ROWS];

		always_ff @(posedge clk) begin
			if (wr_q.mask[b]) begin
				mem[wr_idx] <= wr_q.lanes[b];
			end
			if (rd_en) begin
				rd_data[b] <= mem[rd_idx];   // One-cycle read
			end
		end
	end

endmodule

// File: rtl/line_reader.sv
`timescale 1ns/10ps

module line_reader #(
	parameter int ROWS = 64
) (
	input  logic clk,
	input  logic reset,
	input  logic line_start,
	input  bp_pkg::line_cmd_t line_cmd,
	output logic rd_en,
	output logic [bp_pkg::ROW_W-1:0] rd_row,
	input  bp_pkg::data_t rd_data [bp_pkg::NUM_BANKS],
	output logic out_valid,
	output bp_pkg::data_t out_data,
	output logic line_done,
	output logic line_busy
);
	import bp_pkg::*;

	localparam int BANK_W = ADDR_W - ROW_W;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(ROWS * NUM_BANKS - 1);

	logic [ADDR_W-1:0] addr_q;
	logic [LEN_W-1:0] cnt_q;        // Words left to issue
	logic first_q;
	logic pad_q;
	logic issue;
	logic accept;

	// Stage 1, alongside the bank read
	logic v1;
	logic [BANK_W-1:0] bank1;
	logic first1;
	logic last1;
	data_t lane_pick;

	assign issue     = cnt_q != '0;
	assign accept    = line_start && !line_busy;
	assign rd_en     = issue;
	assign rd_row    = addr_q[ADDR_W-1:BANK_W];
	assign line_busy = issue | v1;   // Drops with the last word

	////////////////////
	// Address counter
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt_q   <= '0;
			first_q <= 1'b0;
		end else if (accept) begin
			cnt_q   <= line_cmd.len;
			first_q <= 1'b1;
		end else if (issue) begin
			cnt_q   <= cnt_q - 1'b1;
			first_q <= 1'b0;
		end
		if (accept) begin
			addr_q <= ADDR_W'(line_cmd.st_addr % (ROWS * NUM_BANKS));
			pad_q  <= line_cmd.pad;
		end else if (issue) begin
			addr_q <= (addr_q == LAST_ADDR) ? '0 : addr_q + 1'b1;   // Wrap
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			v1 <= 1'b0;
		end else begin
			v1 <= issue;
		end
		bank1  <= addr_q[BANK_W-1:0];
		first1 <= first_q;
		last1  <= cnt_q == LEN_W'(1);
	end

	// Edge words zeroed for padding
	assign lane_pick = (pad_q && (first1 || last1)) ? '0 : rd_data[bank1];

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			line_done <= 1'b0;
		end else begin
			out_valid <= v1;
			line_done <= v1 && last1;
		end
		out_data <= lane_pick;
	end

endmodule

// File: rtl/pool_buffer_top.sv
`timescale 1ns/10ps

module pool_buffer_top #(
	parameter int ROWS = 64
) (
	input  logic clk,
	input  logic reset,
	input  logic fill_active,
	input  bp_pkg::wr_req_t fill,
	input  logic wb_conf,
	input  bp_pkg::wb_cfg_t wb_cfg,
	input  logic res_valid,
	input  bp_pkg::result_u res,
	input  logic line_start,
	input  bp_pkg::line_cmd_t line_cmd,
	output logic out_valid,
	output bp_pkg::data_t out_data,
	output logic line_done,
	output logic line_busy
);
	import bp_pkg::*;

	wr_req_t wb_req;                // Writer to buffer
	logic rd_en;
	logic [ROW_W-1:0] rd_row;
	data_t rd_data [NUM_BANKS];

	result_writer writer_i (
		.clk       (clk),
		.reset     (reset),
		.wb_conf   (wb_conf),
		.wb_cfg    (wb_cfg),
		.res_valid (res_valid),
		.res       (res),
		.wb_req    (wb_req)
	);

	bank_buffer #(
		.ROWS (ROWS)
	) buffer_i (
		.clk         (clk),
		.reset       (reset),
		.fill_active (fill_active),
		.fill        (fill),
		.wb_req      (wb_req),
		.rd_en       (rd_en),
		.rd_row      (rd_row),
		.rd_data     (rd_data)
	);

	line_reader #(
		.ROWS (ROWS)
	) reader_i (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.line_cmd   (line_cmd),
		.rd_en      (rd_en),
		.rd_row     (rd_row),
		.rd_data    (rd_data),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.line_done  (line_done),
		.line_busy  (line_busy)
	);

endmodule

// File: tb/pool_buffer_tb.sv
`timescale 1ns/10ps

module pool_buffer_tb;
	import bp_pkg::*;

	localparam int ROWS = 64;
	localparam int N_TESTS = 8;
	localparam int MAX_LEN = 256;
	localparam int K_FILL = 0, K_WB = 1, K_OVERLAP = 2;

	typedef struct {
		string name;
		int kind;
		wb_cfg_t cfg;
		int fill_row;
		int count;                  // Results or fill requests
		line_cmd_t cmd;
		bit restart;                // Second line_start mid-line
	} test_t;

	logic clk = 1'b0;
	logic reset, fill_active, wb_conf, res_valid, line_start;
	wr_req_t fill;
	wb_cfg_t wb_cfg;
	result_u res;
	line_cmd_t line_cmd;
	logic out_valid, line_done, line_busy;
	data_t out_data;

	test_t tests [N_TESTS];
	logic [31:0] lfsr = 32'd97596;
	logic [15:0] model_mem [ROWS * NUM_BANKS];   // Expected buffer by word address
	wb_cfg_t m_cfg = '0;
	logic [ADDR_W-1:0] m_addr = '0;
	int pend_n = 0;                               // Write-back in flight
	logic [ADDR_W-1:0] pend_a [NUM_BANKS];
	logic [15:0] pend_v [NUM_BANKS];
	int errs, words, bad_tests;

	pool_buffer_top #(.ROWS(ROWS)) dut_i (.*);

	always #20 clk = ~clk;

	// Timeout from the test count and the longest line
	initial begin
		#(longint'(N_TESTS) * (300 + 4 * MAX_LEN) * 40);
		$display("Timeout: the simulation ran past its time limit");
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return r;
	endfunction

	function automatic lane_t rand_lane();
		if (take_bits(2) == 0) begin
			return take_bits(1) ? 24'h7f_fff0 : 24'h80_000f;   // Forces saturation
		end
		return lane_t'(take_bits(LANE_W));
	endfunction

	// Shift, then ReLU, then clamp to 16 bits
	function automatic logic [15:0] scaled_word(input lane_t lane, input int sh,
			input bit relu);
		longint v;
		v = lane;
		v = v >>> sh;
		if (relu && v < 0) v = 0;
		if (v > 32767) v = 32767;
		if (v < -32768) v = -32768;
		return v[15:0];
	endfunction

	task automatic clear_inputs();
		fill_active = 0;
		fill = '0;
		wb_conf = 0;
		wb_cfg = '0;
		res_valid = 0;
		res = '0;
		line_start = 0;
		line_cmd = '0;
	endtask

	task automatic random_result();
		for (int k = 0; k < NUM_BANKS; k++) res.quad[k] = rand_lane();
	endtask

	// Model the coming rising edge and wait for the next falling edge
	task automatic clock_step();
		if (fill_active) begin
			for (int k = 0; k < NUM_BANKS; k++)
				if (fill.mask[k]) model_mem[8'(fill.row * 4 + k)] = fill.lanes[k];
		end else begin
			for (int i = 0; i < pend_n; i++) model_mem[pend_a[i]] = pend_v[i];
		end
		pend_n = 0;
		if (res_valid && m_cfg.pooled) begin
			pend_a[0] = m_addr;
			pend_v[0] = scaled_word(res.single.value, int'(m_cfg.shift), m_cfg.relu);
			pend_n = 1;
			m_addr = m_addr + 8'd1;
		end else if (res_valid) begin
			for (int k = 0; k < NUM_BANKS; k++) begin
				pend_a[k] = 8'(m_addr + k);
				pend_v[k] = scaled_word(res.quad[k], int'(m_cfg.shift), m_cfg.relu);
			end
			pend_n = NUM_BANKS;
			m_addr = m_addr + 8'd4;
		end
		if (wb_conf) begin
			m_cfg = wb_cfg;
			m_addr = wb_cfg.st_addr;
		end
		@(negedge clk);
	endtask

	task automatic set_entry(input int i, input string name, input int kind,
			input wb_cfg_t cfg, input int fill_row, input int count, input line_cmd_t cmd,
			input bit restart);
		tests[i] = '{name, kind, cfg, fill_row, count, cmd, restart};
	endtask

	////////////////////
	// Test phases
	////////////////////

	task automatic fill_rows(input int row0, input int count, input bit full);
		for (int i = 0; i < count; i++) begin
			fill_active = 1;
			fill.row = full ? 6'(row0 + i) : 6'(row0 + i / 2);   // Masked fills pair up
			fill.mask = full ? 4'hf : 4'(take_bits(4));
			for (int k = 0; k < NUM_BANKS; k++)
				fill.lanes[k] = full ? {8'(i * 4 + k) ^ 8'h5c, ~8'(i * 4 + k)}
					: 16'(take_bits(16));
			clock_step();
		end
		clear_inputs();
		clock_step();
		clock_step();
	endtask

	task automatic write_back(input int t);
		wb_conf = 1;
		wb_cfg = tests[t].cfg;
		clock_step();
		wb_conf = 0;
		for (int i = 0; i < tests[t].count; i++) begin
			if (tests[t].kind == K_OVERLAP) begin
				fill_active = 1;
				fill.row = 6'(tests[t].fill_row + i);
				fill.mask = 4'(take_bits(4));
				for (int k = 0; k < NUM_BANKS; k++) fill.lanes[k] = 16'(take_bits(16));
			end
			res_valid = 1;
			random_result();
			clock_step();
		end
		if (tests[t].kind == K_OVERLAP) begin
			res_valid = 0;
			fill.mask = '0;                          // Last request still lost
			clock_step();
			fill_active = 0;
			for (int i = 0; i < tests[t].count; i++) begin
				res_valid = 1;
				random_result();
				clock_step();
			end
		end
		clear_inputs();
		clock_step();
		clock_step();
	endtask

	task automatic read_line(input int t);
		line_cmd_t cmd;
		int len, idx, done_k;
		logic [15:0] exp;
		cmd = tests[t].cmd;
		len = int'(cmd.len);
		idx = 0;
		done_k = -1;
		line_start = 1;
		line_cmd = cmd;
		for (int k = 1; k <= len + 11 && (done_k < 0 || k <= done_k + 3); k++) begin
			@(negedge clk);
			line_start = tests[t].restart && k == 2;
			if (line_start) line_cmd = '{8'd3, 9'd5, 1'b0};
			if (out_valid) begin
				assert (idx < len) else begin
					$display("%s: extra word after the end of the line", tests[t].name);
					errs++;
				end
				exp = model_mem[8'(cmd.st_addr + idx)];
				if (cmd.pad && (idx == 0 || idx == len - 1)) begin
					exp = '0;                            // Padded edge
				end
				assert (out_data === exp) else begin
					$display("FAILED %s word %0d: expected %h, actual %h",
						tests[t].name, idx, exp, out_data);
					errs++;
				end
				assert (k == 3 + idx) else begin
					$display("%s: word %0d came at cycle %0d, not %0d",
						tests[t].name, idx, k, 3 + idx);
					errs++;
				end
				assert (line_done === (idx == len - 1)) else begin
					$display("%s: line_done wrong at word %0d", tests[t].name, idx);
					errs++;
				end
				assert (line_busy === (idx < len - 1)) else begin
					$display("%s: line_busy wrong at word %0d", tests[t].name, idx);
					errs++;
				end
				if (line_done) begin
					done_k = k;
				end
				idx++;
			end else begin
				assert (line_done !== 1'b1) else begin
					$display("%s: line_done without a word", tests[t].name);
					errs++;
				end
				assert (done_k < 0 || line_busy === 1'b0) else begin
					$display("%s: line_busy high after the line ended", tests[t].name);
					errs++;
				end
			end
		end
		assert (idx == len) else begin
			$display("%s: %0d words arrived instead of %0d", tests[t].name, idx, len);
			errs++;
		end
		clear_inputs();
		words = idx;
	endtask

	initial begin
		clear_inputs();
		reset = 1;
		bad_tests = 0;
		set_entry(0, "unpooled_s4", K_WB, '{8'd8, 1'b0, 1'b0, 5'd4}, 0, 4,
			'{8'd8, 9'd16, 1'b0}, 0);
		set_entry(1, "unpooled_s9", K_WB, '{8'd40, 1'b0, 1'b0, 5'd9}, 0, 3,
			'{8'd40, 9'd12, 1'b0}, 0);
		set_entry(2, "pooled_relu", K_WB, '{8'd81, 1'b1, 1'b1, 5'd2}, 0, 11,
			'{8'd81, 9'd11, 1'b0}, 0);
		set_entry(3, "fill_mask", K_FILL, '0, 30, 6, '{8'd120, 9'd12, 1'b0}, 0);
		set_entry(4, "fill_overlap", K_OVERLAP, '{8'd160, 1'b0, 1'b0, 5'd3}, 40, 4,
			'{8'd160, 9'd32, 1'b0}, 0);
		set_entry(5, "pad_line", K_WB, '{8'd200, 1'b1, 1'b0, 5'd0}, 0, 20,
			'{8'd198, 9'd26, 1'b1}, 0);
		set_entry(6, "busy_reject", K_WB, '{8'd240, 1'b0, 1'b1, 5'd6}, 0, 2,
			'{8'd240, 9'd40, 1'b1}, 1);
		set_entry(7, "full_sweep", K_WB, '{8'd0, 1'b1, 1'b0, 5'd1}, 0, 0,
			'{8'd0, 9'd256, 1'b0}, 0);
		repeat (10) @(negedge clk);
		reset = 0;
		assert (!out_valid && !line_done && !line_busy) else begin
			$display("Outputs not idle after reset");
			bad_tests++;
		end
		fill_rows(0, ROWS, 1);                        // Known contents everywhere

		for (int t = 0; t < N_TESTS; t++) begin
			errs = 0;
			if (tests[t].kind == K_FILL) fill_rows(tests[t].fill_row, tests[t].count, 0);
			else write_back(t);
			read_line(t);
			$display("%-13s %0d words read, %0d errors", tests[t].name, words, errs);
			if (errs != 0) bad_tests++;
		end

		$display("Tests run: %0d, tests with errors: %0d", N_TESTS, bad_tests);
		if (bad_tests == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: filelist.f
rtl/bp_pkg.sv
rtl/result_writer.sv
rtl/bank_buffer.sv
rtl/line_reader.sv
rtl/pool_buffer_top.sv
tb/pool_buffer_tb.sv

// File: Makefile
SIM = obj_dir/pool_buffer_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): filelist.f rtl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module pool_buffer_tb -o pool_buffer_sim

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
